// File: Bender.yml
package:
  name: mem_write

sources:
  - files:
      - src/mem_write_pkg.sv
      - src/slot_tracker.sv
      - src/order_fifo.sv
      - src/line_buffer.sv
      - src/write_ctrl.sv
      - src/mem_write_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/mem_write_assert.sv
      - test/tb_mem_write.sv

// File: build.f
src/mem_write_pkg.sv
src/slot_tracker.sv
src/order_fifo.sv
src/line_buffer.sv
src/write_ctrl.sv
src/mem_write_top.sv
test/tb_clk_gen.sv
test/mem_write_assert.sv
test/tb_mem_write.sv

// File: src/line_buffer.sv
`timescale 1ns/10ps

module line_buffer
    import mem_write_pkg::*;
#(
    parameter int LINE_WORD_NUM = 8
) (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_load,
    input  logic                             i_is_single,
    input  word [LINE_WORD_NUM-1:0]          i_line,
    input  word                              i_word,
    input  logic [$clog2(LINE_WORD_NUM)-1:0] i_beat,
    output word                              o_wdata
);

    word [LINE_WORD_NUM-1:0] r_line;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_line <= '0;
        end else if (i_load) begin
            if (i_is_single) begin
                r_line[0] <= i_word;   // uncached store is one beat
            end else begin
                r_line <= i_line;
            end
        end
    end

    assign o_wdata = r_line[i_beat];

endmodule

// File: src/mem_write_pkg.sv
package mem_write_pkg;

    typedef logic [31:0] word;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // one write as seen from the core side
    typedef struct packed {
        word        addr;
        logic [3:0] len;        // beats minus one
        logic [2:0] size;
        logic [3:0] wen;        // byte strobe
    } mem_write_req;

    // master side of the AXI3 write channels
    typedef struct packed {
        logic [3:0] awid;
        word        awaddr;
        logic [3:0] awlen;
        logic [2:0] awsize;
        logic [1:0] awburst;
        logic [1:0] awlock;
        logic [3:0] awcache;
        logic [2:0] awprot;
        logic       awvalid;
        logic [3:0] wid;
        word        wdata;
        logic [3:0] wstrb;
        logic       wlast;
        logic       wvalid;
        logic       bready;
    } axi_w_req;

    // slave side of the AXI3 write channels
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic [3:0] bid;
    } axi_w_resp;

endpackage

// File: src/mem_write_top.sv
`timescale 1ns/10ps

module mem_write_top
    import mem_write_pkg::*;
#(
    parameter int FIFO_DEPTH    = 16,
    parameter int LINE_WORD_NUM = 8
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_dcache_we,
    input  mem_write_req                  i_dcache_req,
    input  word [LINE_WORD_NUM-1:0]       i_dcache_data,
    input  logic                          i_sram_we,
    input  mem_write_req                  i_sram_req,
    input  word                           i_sram_data,
    input  axi_w_resp                     i_axi_resp,
    output logic [$clog2(FIFO_DEPTH)-2:0] o_dcache_lock,
    output logic                          o_dcache_full,
    output logic [$clog2(FIFO_DEPTH)-2:0] o_sram_lock,
    output logic                          o_sram_full,
    output logic [$clog2(FIFO_DEPTH)-1:0] o_key,
    output logic                          o_empty,
    output logic                          o_sram_start,
    output logic                          o_sram_end,
    output logic                          o_dcache_start,
    output logic                          o_dcache_end,
    output logic                          o_write_process,
    output word                           o_write_address,
    output axi_w_req                      o_axi_req
);

    localparam int SLOTS = FIFO_DEPTH / 2;
    localparam int LW    = $clog2(SLOTS);
    localparam logic [LW:0] SRAM_LIMIT = (LW+1)'(SLOTS - 2);

    typedef struct packed {
        logic          is_sram;   // 1 = uncached
        logic [LW-1:0] slot;
    } write_key;

    typedef struct packed {
        write_key     key;
        mem_write_req req;
        word          data;
    } write_entry;

    logic                             r_sram_push;
    logic                             r_dcache_push;
    write_entry                       r_sram_entry;
    write_entry                       r_dcache_entry;
    write_entry                       head;
    logic [LW:0]                      sram_count;
    logic                             pop;
    logic                             load;
    logic [$clog2(LINE_WORD_NUM)-1:0] beat;
    word                              wdata;
    axi_w_req                         ctrl_req;

    slot_tracker #(.SLOTS(SLOTS)) u_dcache_slots (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_alloc     (i_dcache_we),
        .i_free      (pop && !head.key.is_sram),
        .i_free_slot (head.key.slot),
        .o_lock      (o_dcache_lock),
        .o_full      (o_dcache_full),
        .o_count     ()
    );

    slot_tracker #(.SLOTS(SLOTS)) u_sram_slots (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_alloc     (i_sram_we),
        .i_free      (pop && head.key.is_sram),
        .i_free_slot (head.key.slot),
        .o_lock      (o_sram_lock),
        .o_full      (),
        .o_count     (sram_count)
    );

    assign o_sram_full = (sram_count >= SRAM_LIMIT);   // two-slot margin

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_sram_push   <= 1'b0;
            r_dcache_push <= 1'b0;
        end else begin
            r_sram_push   <= i_sram_we;
            r_dcache_push <= i_dcache_we;
        end
    end

    // entries go in a cycle after the lock is taken
    always_ff @(posedge i_clk) begin
        if (i_sram_we) begin
            r_sram_entry <= '{key: '{is_sram: 1'b1, slot: o_sram_lock},
                              req: i_sram_req, data: i_sram_data};
        end
        if (i_dcache_we) begin
            r_dcache_entry <= '{key: '{is_sram: 1'b0, slot: o_dcache_lock},
                                req: i_dcache_req, data: '0};
        end
    end

    order_fifo #(
        .DEPTH   (FIFO_DEPTH),
        .entry_t (write_entry)
    ) u_order_fifo (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_push_a (r_sram_push),
        .i_data_a (r_sram_entry),
        .i_push_b (r_dcache_push),
        .i_data_b (r_dcache_entry),
        .i_pop    (pop),
        .o_data   (head),
        .o_empty  (o_empty)
    );

    line_buffer #(.LINE_WORD_NUM(LINE_WORD_NUM)) u_line_buffer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_load      (load),
        .i_is_single (head.key.is_sram),
        .i_line      (i_dcache_data),
        .i_word      (head.data),
        .i_beat      (beat),
        .o_wdata     (wdata)
    );

    write_ctrl #(.LINE_WORD_NUM(LINE_WORD_NUM)) u_write_ctrl (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_empty         (o_empty),
        .i_head_req      (head.req),
        .i_head_is_sram  (head.key.is_sram),
        .i_axi_resp      (i_axi_resp),
        .o_axi_req       (ctrl_req),
        .o_load          (load),
        .o_beat          (beat),
        .o_pop           (pop),
        .o_sram_start    (o_sram_start),
        .o_dcache_start  (o_dcache_start),
        .o_sram_end      (o_sram_end),
        .o_dcache_end    (o_dcache_end),
        .o_write_process (o_write_process)
    );

    always_comb begin
        o_axi_req       = ctrl_req;
        o_axi_req.wdata = wdata;
    end

    assign o_key           = head.key;   // dcache reads its line by this
    assign o_write_address = head.req.addr;

endmodule

// File: src/order_fifo.sv
`timescale 1ns/10ps

module order_fifo #(
    parameter int  DEPTH   = 16,
    parameter type entry_t = logic [31:0]
) (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_push_a,
    input  entry_t i_data_a,
    input  logic   i_push_b,
    input  entry_t i_data_b,
    input  logic   i_pop,
    output entry_t o_data,
    output logic   o_empty
);

    localparam int PW = $clog2(DEPTH);

    entry_t        mem [DEPTH];
    logic [PW-1:0] r_wptr;
    logic [PW-1:0] r_rptr;
    logic [PW-1:0] wptr_b;
    logic [PW:0]   r_count;
    logic [1:0]    n_push;

    // b lands behind a when both push
    assign wptr_b = i_push_a ? PW'(r_wptr + 1'b1) : r_wptr;
    assign n_push = {1'b0, i_push_a} + {1'b0, i_push_b};

    always_ff @(posedge i_clk) begin
        if (i_push_a) begin
            mem[r_wptr] <= i_data_a;
        end
        if (i_push_b) begin
            mem[wptr_b] <= i_data_b;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wptr  <= '0;
            r_rptr  <= '0;
            r_count <= '0;
        end else begin
            r_wptr  <= r_wptr + PW'(n_push);
            r_count <= r_count + (PW+1)'(n_push) - (PW+1)'(i_pop);
            if (i_pop) begin
                r_rptr <= r_rptr + 1'b1;
            end
        end
    end

    assign o_data  = mem[r_rptr];   // head, no read latency
    assign o_empty = (r_count == '0);

endmodule

// File: src/slot_tracker.sv
`timescale 1ns/10ps

module slot_tracker #(
    parameter int SLOTS = 8
) (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_alloc,
    input  logic                     i_free,
    input  logic [$clog2(SLOTS)-1:0] i_free_slot,
    output logic [$clog2(SLOTS)-1:0] o_lock,
    output logic                     o_full,
    output logic [$clog2(SLOTS):0]   o_count
);

    localparam int SW = $clog2(SLOTS);

    logic [SLOTS-1:0] r_busy;
    logic [SW:0]      r_count;

    // lowest clear bit wins
    always_comb begin
        o_lock = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (!r_busy[i]) begin
                o_lock = SW'(i);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_busy  <= '0;
            r_count <= '0;
        end else begin
            if (i_alloc) begin
                r_busy[o_lock] <= 1'b1;
            end
            if (i_free) begin
                r_busy[i_free_slot] <= 1'b0;   // never the slot being taken
            end
            case ({i_alloc, i_free})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    assign o_full  = &r_busy;
    assign o_count = r_count;

endmodule

// File: src/write_ctrl.sv
`timescale 1ns/10ps

module write_ctrl
    import mem_write_pkg::*;
#(
    parameter int LINE_WORD_NUM = 8
) (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_empty,
    input  mem_write_req                     i_head_req,
    input  logic                             i_head_is_sram,
    input  axi_w_resp                        i_axi_resp,
    output axi_w_req                         o_axi_req,
    output logic                             o_load,
    output logic [$clog2(LINE_WORD_NUM)-1:0] o_beat,
    output logic                             o_pop,
    output logic                             o_sram_start,
    output logic                             o_dcache_start,
    output logic                             o_sram_end,
    output logic                             o_dcache_end,
    output logic                             o_write_process
);

    localparam int BW = $clog2(LINE_WORD_NUM);

    logic          r_awvalid;
    logic          r_wvalid;
    logic          r_process;
    logic [BW-1:0] r_beat;
    logic          aw_hs;
    logic          w_hs;
    logic          last_beat;

    assign aw_hs     = r_awvalid && i_axi_resp.awready;
    assign w_hs      = r_wvalid && i_axi_resp.wready;
    assign last_beat = (4'(r_beat) == i_head_req.len);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_awvalid <= 1'b0;
            r_wvalid  <= 1'b0;
            r_process <= 1'b0;
            r_beat    <= '0;
        end else begin
            if (aw_hs) begin
                r_awvalid <= 1'b0;
            end else if (!r_awvalid && !r_process && !i_empty) begin
                r_awvalid <= 1'b1;   // next head, one burst at a time
            end

            if (aw_hs) begin
                r_process <= 1'b1;
                r_wvalid  <= 1'b1;
                r_beat    <= '0;
            end else begin
                if (w_hs) begin
                    r_beat <= r_beat + 1'b1;
                    if (last_beat) begin
                        r_wvalid <= 1'b0;
                    end
                end
                if (o_pop) begin
                    r_process <= 1'b0;
                end
            end
        end
    end

    assign o_load          = aw_hs;
    assign o_beat          = r_beat;
    assign o_pop           = i_axi_resp.bvalid && r_process;   // bresp ignored
    assign o_sram_start    = aw_hs && i_head_is_sram;
    assign o_dcache_start  = aw_hs && !i_head_is_sram;
    assign o_sram_end      = o_pop && i_head_is_sram;
    assign o_dcache_end    = o_pop && !i_head_is_sram;
    assign o_write_process = r_process;

    always_comb begin
        o_axi_req         = '0;   // ids, lock, cache, prot stay zero
        o_axi_req.awaddr  = i_head_req.addr;
        o_axi_req.awlen   = i_head_req.len;
        o_axi_req.awsize  = i_head_req.size;
        o_axi_req.awburst = AXI_BURST_INCR;
        o_axi_req.awvalid = r_awvalid;
        o_axi_req.wstrb   = i_head_req.wen;
        o_axi_req.wlast   = r_wvalid && last_beat;
        o_axi_req.wvalid  = r_wvalid;
        o_axi_req.bready  = 1'b1;
    end

endmodule

// File: test/mem_write_assert.sv
`timescale 1ns/10ps

module mem_write_assert
    import mem_write_pkg::*;
#(
    parameter int BW = 3
) (
    input logic          i_clk,
    input logic          i_rst,
    input axi_w_req      i_req,
    input axi_w_resp     i_resp,
    input logic [BW-1:0] i_beat,
    input logic          i_sram_start,
    input logic          i_dcache_start,
    input logic          i_process
);

    int fail_count = 0;

    assert property (@(posedge i_clk) disable iff (i_rst)
        i_req.awvalid && !i_resp.awready |=> i_req.awvalid && $stable(i_req.awaddr)
            && $stable(i_req.awlen) && $stable(i_req.awsize))
    else begin
        fail_count++;
        $error("awvalid dropped or AW fields changed before awready");
    end

    // beat index selects wdata in the line buffer
    assert property (@(posedge i_clk) disable iff (i_rst)
        i_req.wvalid && !i_resp.wready |=> i_req.wvalid && $stable(i_beat)
            && $stable(i_req.wlast) && $stable(i_req.wstrb))
    else begin
        fail_count++;
        $error("wvalid dropped or W beat changed before wready");
    end

    assert property (@(posedge i_clk) disable iff (i_rst) i_req.wlast |-> i_req.wvalid)
    else begin
        fail_count++;
        $error("wlast without wvalid");
    end

    assert property (@(posedge i_clk) disable iff (i_rst)
        (i_sram_start || i_dcache_start) |-> !i_process)
    else begin
        fail_count++;
        $error("start pulse while a burst is in process");
    end

endmodule

bind write_ctrl mem_write_assert #(.BW(BW)) u_assert (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_req          (o_axi_req),
    .i_resp         (i_axi_resp),
    .i_beat         (o_beat),
    .i_sram_start   (o_sram_start),
    .i_dcache_start (o_dcache_start),
    .i_process      (o_write_process)
);

// File: test/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int HALF_PERIOD = 4
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        #1 o_rst = 1'b0;   // released like any other input
    end

endmodule

// File: test/tb_mem_write.sv
`timescale 1ns/10ps

module tb_mem_write
    import mem_write_pkg::*;
();

    localparam int FIFO_DEPTH    = 16;
    localparam int LINE_WORD_NUM = 8;
    localparam int SLOTS         = FIFO_DEPTH / 2;
    localparam int LW            = $clog2(SLOTS);
    localparam int NUM_PUSH      = 300;
    localparam int MAX_CYCLES    = NUM_PUSH * (LINE_WORD_NUM + 8) * 4;

    typedef struct packed {
        logic          is_sram;
        logic [LW-1:0] slot;
        mem_write_req  req;
        word           data;
    } model_entry;

    logic clk;
    logic rst;
    logic i_dcache_we, i_sram_we;
    mem_write_req i_dcache_req, i_sram_req;
    word i_sram_data;
    word [LINE_WORD_NUM-1:0] dcache_data;
    axi_w_resp i_axi_resp;
    logic [LW-1:0] o_dcache_lock, o_sram_lock;
    logic [LW:0] o_key;
    logic o_dcache_full, o_sram_full, o_empty, o_write_process;
    logic o_sram_start, o_sram_end, o_dcache_start, o_dcache_end;
    word o_write_address;
    axi_w_req axi_req;

    word [LINE_WORD_NUM-1:0] line_mem [SLOTS];   // dcache copy per held lock
    word [LINE_WORD_NUM-1:0] cur_line;
    model_entry exp_q[$];
    model_entry cur;
    logic [SLOTS-1:0] sram_busy, dcache_busy;
    logic b_pending;
    int beat_cnt, pushes, cycles;
    integer seed = 32'h8291;

    tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst(rst));

    mem_write_top #(.FIFO_DEPTH(FIFO_DEPTH), .LINE_WORD_NUM(LINE_WORD_NUM)) UUT (
        .i_clk(clk), .i_rst(rst),
        .i_dcache_we(i_dcache_we), .i_dcache_req(i_dcache_req), .i_dcache_data(dcache_data),
        .i_sram_we(i_sram_we), .i_sram_req(i_sram_req), .i_sram_data(i_sram_data),
        .i_axi_resp(i_axi_resp),
        .o_dcache_lock(o_dcache_lock), .o_dcache_full(o_dcache_full),
        .o_sram_lock(o_sram_lock), .o_sram_full(o_sram_full),
        .o_key(o_key), .o_empty(o_empty),
        .o_sram_start(o_sram_start), .o_sram_end(o_sram_end),
        .o_dcache_start(o_dcache_start), .o_dcache_end(o_dcache_end),
        .o_write_process(o_write_process), .o_write_address(o_write_address),
        .o_axi_req(axi_req)
    );

    always_comb dcache_data = line_mem[o_key[LW-1:0]];   // dcache reads by head key

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    function automatic int lowest_free(input logic [SLOTS-1:0] busy);
        for (int i = 0; i < SLOTS; i++) begin
            if (!busy[i]) return i;
        end
        return -1;
    endfunction

    task automatic drive_slave();
        logic [31:0] r;
        r = $random(seed);
        i_axi_resp.awready = r[0] | r[1];   // ready three cycles in four
        i_axi_resp.wready  = r[2] | r[3];
        i_axi_resp.bvalid  = b_pending && r[4];
    endtask

    task automatic drive_core();
        logic [31:0] r;
        model_entry e;
        i_sram_we   = 1'b0;
        i_dcache_we = 1'b0;
        r = $random(seed);
        compare("o_sram_full", $countones(sram_busy) >= SLOTS - 2, o_sram_full);
        compare("o_dcache_full", &dcache_busy, o_dcache_full);
        if (r[0] && !o_sram_full && pushes < NUM_PUSH) begin
            compare("o_sram_lock", lowest_free(sram_busy), o_sram_lock);
            e = '0;
            e.is_sram       = 1'b1;
            e.slot          = o_sram_lock;
            e.req.addr      = $random(seed);
            e.req.addr[1:0] = 2'b00;
            e.req.size      = 3'd2;
            e.req.wen       = r[7:4];
            e.data          = $random(seed);
            i_sram_we   = 1'b1;
            i_sram_req  = e.req;
            i_sram_data = e.data;
            sram_busy[e.slot] = 1'b1;
            exp_q.push_back(e);   // uncached first on a tie
            pushes++;
        end
        if (r[1] && !o_dcache_full && pushes < NUM_PUSH) begin
            compare("o_dcache_lock", lowest_free(dcache_busy), o_dcache_lock);
            e = '0;
            e.slot     = o_dcache_lock;
            e.req.addr = $random(seed);
            e.req.addr[$clog2(LINE_WORD_NUM)+1:0] = '0;   // line aligned
            e.req.len  = 4'(LINE_WORD_NUM - 1);
            e.req.size = 3'd2;
            e.req.wen  = 4'hf;
            for (int i = 0; i < LINE_WORD_NUM; i++) begin
                line_mem[e.slot][i] = $random(seed);
            end
            i_dcache_we  = 1'b1;
            i_dcache_req = e.req;
            dcache_busy[e.slot] = 1'b1;
            exp_q.push_back(e);
            pushes++;
        end
    endtask

    // handshakes seen here complete at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (axi_req.awvalid && i_axi_resp.awready) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: AW burst issued with no write pending at %0t", $time);
                    stop_on_error();
                end else begin
                    cur = exp_q[0];
                    compare("o_key", {cur.is_sram, cur.slot}, o_key);
                    compare("o_write_address", cur.req.addr, o_write_address);
                    compare("awaddr", cur.req.addr, axi_req.awaddr);
                    compare("awlen", cur.req.len, axi_req.awlen);
                    compare("awsize", cur.req.size, axi_req.awsize);
                    compare("awburst", AXI_BURST_INCR, axi_req.awburst);
                    compare("awid", 4'h0, axi_req.awid);
                    compare("o_sram_start", cur.is_sram, o_sram_start);
                    compare("o_dcache_start", !cur.is_sram, o_dcache_start);
                    cur_line = cur.is_sram ? '0 : line_mem[cur.slot];
                    if (cur.is_sram) cur_line[0] = cur.data;
                    beat_cnt = 0;
                end
            end else begin
                compare("o_sram_start", 1'b0, o_sram_start);
                compare("o_dcache_start", 1'b0, o_dcache_start);
            end
            if (axi_req.wvalid && i_axi_resp.wready) begin
                compare("o_write_process", 1'b1, o_write_process);
                compare("wid", 4'h0, axi_req.wid);
                compare("wdata", cur_line[beat_cnt], axi_req.wdata);
                compare("wstrb", cur.req.wen, axi_req.wstrb);
                compare("wlast", beat_cnt == cur.req.len, axi_req.wlast);
                if (beat_cnt == cur.req.len) b_pending = 1'b1;
                beat_cnt++;
            end
            if (i_axi_resp.bvalid) begin
                compare("bready", 1'b1, axi_req.bready);
                compare("o_write_process", 1'b1, o_write_process);
                compare("o_sram_end", cur.is_sram, o_sram_end);
                compare("o_dcache_end", !cur.is_sram, o_dcache_end);
                compare("beats", cur.req.len + 1, beat_cnt);
                if (cur.is_sram) sram_busy[cur.slot] = 1'b0;
                else dcache_busy[cur.slot] = 1'b0;
                void'(exp_q.pop_front());
                b_pending = 1'b0;
            end else begin
                compare("o_sram_end", 1'b0, o_sram_end);
                compare("o_dcache_end", 1'b0, o_dcache_end);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (UUT.u_write_ctrl.u_assert.fail_count != 0) begin
            $display("ERROR: AXI protocol assertion failed at %0t", $time);
            stop_on_error();
        end else if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            stop_on_error();
        end
    end

    initial begin
        i_dcache_we  = 1'b0;
        i_sram_we    = 1'b0;
        i_dcache_req = '0;
        i_sram_req   = '0;
        i_sram_data  = '0;
        i_axi_resp   = '0;
        sram_busy    = '0;
        dcache_busy  = '0;
        b_pending    = 1'b0;
        pushes       = 0;
        cycles       = 0;
        beat_cnt     = 0;
        for (int s = 0; s < SLOTS; s++) begin
            line_mem[s] = '0;
        end
        wait (!rst);
        @(negedge clk);
        compare("awvalid", 1'b0, axi_req.awvalid);
        compare("wvalid", 1'b0, axi_req.wvalid);
        compare("o_write_process", 1'b0, o_write_process);
        compare("o_empty", 1'b1, o_empty);
        compare("o_sram_full", 1'b0, o_sram_full);
        compare("o_dcache_full", 1'b0, o_dcache_full);
        while (pushes < NUM_PUSH || exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            drive_slave();
            drive_core();
        end
        @(negedge clk);
        compare("o_empty", 1'b1, o_empty);
        compare("o_write_process", 1'b0, o_write_process);
        if (UUT.u_write_ctrl.u_assert.fail_count != 0) begin
            $display("ERROR: AXI protocol assertion failed during the run");
            stop_on_error();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule
